/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^ALL CHECKS PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

/* bus_unit.sv */
//##########################################################
// bus unit
// ADL/ADH/DB internal buses and the external address
//##########################################################
`default_nettype none

module bus_unit (
    input  wire                 i_dl_db,
    input  wire                 i_dl_adh,
    input  wire                 i_pcl_adl,
    input  wire                 i_pch_adh,
    input  wire                 i_add_adl,
    input  wire                 i_zero_adl0,
    input  wire                 i_zero_adl1,
    input  wire                 i_zero_adh1_7,
    input  wire                 i_adl_abl,
    input  wire                 i_adh_abh,
    input  wire cpu_pkg::data_t i_pcl,
    input  wire cpu_pkg::data_t i_pch,
    input  wire cpu_pkg::data_t i_s,
    input  wire cpu_pkg::data_t i_add,
    input  wire cpu_pkg::data_t i_data,

    output cpu_pkg::data_t o_adl,
    output cpu_pkg::data_t o_adh,
    output cpu_pkg::data_t o_db,
    output cpu_pkg::addr_t o_addr
);

    cpu_pkg::data_t vec_pattern;

    // precharged ADL with the vector pull-downs on bits 0 and 1
    assign vec_pattern = ~{6'b000000, i_zero_adl1, i_zero_adl0};

    // S arrives already precharged when not selected
    assign o_adl = i_pcl_adl ? i_pcl :
                   i_add_adl ? i_add :
                   (i_s & vec_pattern);

    always_comb
    begin
        if (i_pch_adh)
        begin
            o_adh = i_pch;
        end
        else if (i_dl_adh)
        begin
            o_adh = i_data;
        end
        else if (i_zero_adh1_7)
        begin
            // stack page
            o_adh = cpu_pkg::STACK_PAGE;
        end
        else
        begin
            o_adh = 8'hFF;
        end
    end

    assign o_db = i_dl_db ? i_data : 8'hFF;

    // unselected address halves see the precharged vector page
    assign o_addr = {i_adh_abh ? o_adh : 8'hFF, i_adl_abl ? o_adl : vec_pattern};

endmodule

`default_nettype wire

/* cpu_pkg.sv */
//##########################################################
// cpu package
// shared widths, timing states, opcodes and vector bytes
// for the 6502 front-end model
//##########################################################
`default_nettype none

package cpu_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;

    // timing control unit states
    typedef enum logic [3:0] {
        T0 = 4'd0,
        T1 = 4'd1,
        T2 = 4'd2,
        T3 = 4'd3,
        T4 = 4'd4,
        T5 = 4'd5,
        T6 = 4'd6,
        T7 = 4'd7
    } tcu_t;

    localparam data_t OPCODE_BRK = 8'h00;
    localparam data_t OPCODE_NOP = 8'hEA;

    // reset vector lives at FFFC/FFFD
    localparam data_t VEC_RESET_LO = 8'hFC;
    localparam data_t VEC_RESET_HI = 8'hFD;

    localparam data_t STACK_PAGE = 8'h01;

    // reset enters the BRK sequence at the first stack cycle
    localparam tcu_t TCU_RESET = T2;

endpackage

`default_nettype wire

/* cpu_sva.sv */
//##########################################################
// bound assertions for the cpu top
// TCU range, T state order and fetch strobe placement
//##########################################################
`default_nettype none

module cpu_sva (
    input wire                 i_clk,
    input wire                 i_reset,
    input wire cpu_pkg::tcu_t  i_tcu,
    input wire cpu_pkg::data_t i_ir,
    input wire                 i_sync
);

    tcu_in_range: assert property (@(posedge i_clk) disable iff (i_reset)
        i_tcu <= cpu_pkg::T7)
        else $error("TCU left the T0 to T7 range");

    // fetch only at T0, or at T7 at the end of BRK
    sync_at_fetch: assert property (@(posedge i_clk) disable iff (i_reset)
        i_sync |-> (i_tcu == cpu_pkg::T0) ||
                   (i_tcu == cpu_pkg::T7 && i_ir == cpu_pkg::OPCODE_BRK))
        else $error("o_sync high outside a fetch cycle");

    vector_then_fetch: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_tcu == cpu_pkg::T6) |=> (i_tcu == cpu_pkg::T7))
        else $error("T6 not followed by T7");

endmodule

bind cpu_top cpu_sva u_cpu_sva (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_tcu   (tcu),
    .i_ir    (ir),
    .i_sync  (o_sync)
);

`default_nettype wire

/* cpu_top.sv */
//##########################################################
// cpu top
// decode ROM, timing, PC, stack/adder and bus unit
//##########################################################
`default_nettype none

module cpu_top #(
    parameter cpu_pkg::data_t S_RESET = 8'h00
) (
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  wire cpu_pkg::data_t i_data,

    output cpu_pkg::addr_t o_addr,
    output logic           o_rw,
    output logic           o_sync
);

    cpu_pkg::tcu_t  tcu;
    cpu_pkg::tcu_t  tcu_next;
    cpu_pkg::data_t ir;

    // control strobes
    logic pcl_pcl, adl_pcl, i_pc, pch_pch, adh_pch;
    logic s_adl, sb_s, adl_add, sb_add, db_add, zero_add, sums, add_sb;
    logic dl_db, dl_adh, pcl_adl, pch_adh, add_adl;
    logic zero_adl0, zero_adl1, zero_adh1_7, adl_abl, adh_abh;

    // datapath values
    cpu_pkg::data_t pcl;
    cpu_pkg::data_t pch;
    cpu_pkg::data_t s;
    cpu_pkg::data_t add;
    cpu_pkg::data_t adl;
    cpu_pkg::data_t adh;
    cpu_pkg::data_t db;

    decoder u_decoder (
        .i_ir          (ir),
        .i_tcu         (tcu),
        .o_tcu         (tcu_next),
        .o_sync        (o_sync),
        .o_rw          (o_rw),
        .o_pcl_pcl     (pcl_pcl),
        .o_adl_pcl     (adl_pcl),
        .o_i_pc        (i_pc),
        .o_pch_pch     (pch_pch),
        .o_adh_pch     (adh_pch),
        .o_s_adl       (s_adl),
        .o_sb_s        (sb_s),
        .o_adl_add     (adl_add),
        .o_sb_add      (sb_add),
        .o_db_add      (db_add),
        .o_zero_add    (zero_add),
        .o_sums        (sums),
        .o_add_sb      (add_sb),
        .o_dl_db       (dl_db),
        .o_dl_adh      (dl_adh),
        .o_pcl_adl     (pcl_adl),
        .o_pch_adh     (pch_adh),
        .o_add_adl     (add_adl),
        .o_zero_adl0   (zero_adl0),
        .o_zero_adl1   (zero_adl1),
        .o_zero_adh1_7 (zero_adh1_7),
        .o_adl_abl     (adl_abl),
        .o_adh_abh     (adh_abh)
    );

    timing_ctrl u_timing_ctrl (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_tcu_next (tcu_next),
        .i_sync     (o_sync),
        .i_data     (i_data),
        .o_tcu      (tcu),
        .o_ir       (ir)
    );

    program_counter u_program_counter (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_pcl_pcl (pcl_pcl),
        .i_adl_pcl (adl_pcl),
        .i_pch_pch (pch_pch),
        .i_adh_pch (adh_pch),
        .i_i_pc    (i_pc),
        .i_adl     (adl),
        .i_adh     (adh),
        .o_pcl     (pcl),
        .o_pch     (pch)
    );

    stack_adder #(
        .S_RESET (S_RESET)
    ) u_stack_adder (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_s_adl    (s_adl),
        .i_sb_s     (sb_s),
        .i_adl_add  (adl_add),
        .i_sb_add   (sb_add),
        .i_db_add   (db_add),
        .i_zero_add (zero_add),
        .i_sums     (sums),
        .i_add_sb   (add_sb),
        .i_adl      (adl),
        .i_db       (db),
        .o_s        (s),
        .o_add      (add)
    );

    bus_unit u_bus_unit (
        .i_dl_db       (dl_db),
        .i_dl_adh      (dl_adh),
        .i_pcl_adl     (pcl_adl),
        .i_pch_adh     (pch_adh),
        .i_add_adl     (add_adl),
        .i_zero_adl0   (zero_adl0),
        .i_zero_adl1   (zero_adl1),
        .i_zero_adh1_7 (zero_adh1_7),
        .i_adl_abl     (adl_abl),
        .i_adh_abh     (adh_abh),
        .i_pcl         (pcl),
        .i_pch         (pch),
        .i_s           (s),
        .i_add         (add),
        .i_data        (i_data),
        .o_adl         (adl),
        .o_adh         (adh),
        .o_db          (db),
        .o_addr        (o_addr)
    );

endmodule

`default_nettype wire

/* decoder.sv */
//##########################################################
// decode ROM
// maps (IR, TCU) onto the datapath control lines and
// the next timing state
//##########################################################
`default_nettype none

module decoder (
    input  wire cpu_pkg::data_t i_ir,
    input  wire cpu_pkg::tcu_t  i_tcu,

    output cpu_pkg::tcu_t o_tcu,
    output logic          o_sync,
    output logic          o_rw,

    // program counter
    output logic o_pcl_pcl,
    output logic o_adl_pcl,
    output logic o_i_pc,
    output logic o_pch_pch,
    output logic o_adh_pch,

    // stack pointer and adder
    output logic o_s_adl,
    output logic o_sb_s,
    output logic o_adl_add,
    output logic o_sb_add,
    output logic o_db_add,
    output logic o_zero_add,
    output logic o_sums,
    output logic o_add_sb,

    // bus sources and address bus
    output logic o_dl_db,
    output logic o_dl_adh,
    output logic o_pcl_adl,
    output logic o_pch_adh,
    output logic o_add_adl,
    output logic o_zero_adl0,
    output logic o_zero_adl1,
    output logic o_zero_adh1_7,
    output logic o_adl_abl,
    output logic o_adh_abh
);

    logic is_brk;

    assign is_brk = (i_ir == cpu_pkg::OPCODE_BRK);

    always_comb
    begin
        // step to the next T state unless the column says otherwise
        o_tcu = cpu_pkg::tcu_t'(i_tcu + 4'd1);

        // every cycle is a read in this model
        o_rw = 1'b1;
        o_sync = 1'b0;

        o_pcl_pcl = 1'b0;
        o_adl_pcl = 1'b0;
        o_i_pc = 1'b0;
        o_pch_pch = 1'b0;
        o_adh_pch = 1'b0;
        o_s_adl = 1'b0;
        o_sb_s = 1'b0;
        o_adl_add = 1'b0;
        o_sb_add = 1'b0;
        o_db_add = 1'b0;
        o_zero_add = 1'b0;
        o_sums = 1'b0;
        o_add_sb = 1'b0;
        o_dl_db = 1'b0;
        o_dl_adh = 1'b0;
        o_pcl_adl = 1'b0;
        o_pch_adh = 1'b0;
        o_add_adl = 1'b0;
        o_zero_adl0 = 1'b0;
        o_zero_adl1 = 1'b0;
        o_zero_adh1_7 = 1'b0;
        o_adl_abl = 1'b0;
        o_adh_abh = 1'b0;

        case (i_tcu)
            cpu_pkg::T0:
            begin
                // opcode fetch at PC, then PC moves on
                o_sync = 1'b1;
                o_pcl_adl = 1'b1;
                o_adl_abl = 1'b1;
                o_pch_adh = 1'b1;
                o_adh_abh = 1'b1;
                o_pcl_pcl = 1'b1;
                o_pch_pch = 1'b1;
                o_i_pc = 1'b1;
            end
            cpu_pkg::T1:
            begin
                // PC on the address bus, no increment
                o_pcl_adl = 1'b1;
                o_adl_abl = 1'b1;
                o_pch_adh = 1'b1;
                o_adh_abh = 1'b1;
                if (!is_brk)
                begin
                    // NOP column, back to the fetch
                    o_pcl_pcl = 1'b1;
                    o_pch_pch = 1'b1;
                    o_tcu = cpu_pkg::T0;
                end
            end
            default:
            begin
                if (!is_brk)
                begin
                    // only BRK runs past T1
                    o_tcu = cpu_pkg::T0;
                end
                else
                begin
                    case (i_tcu)
                        cpu_pkg::T2:
                        begin
                            // read 01:S, ADD = S - 1
                            o_s_adl = 1'b1;
                            o_adl_abl = 1'b1;
                            o_zero_adh1_7 = 1'b1;
                            o_adh_abh = 1'b1;
                            o_adl_add = 1'b1;
                            o_sb_add = 1'b1;
                            o_sums = 1'b1;
                        end
                        cpu_pkg::T3:
                        begin
                            // read 01:ADD, decrement again
                            o_add_adl = 1'b1;
                            o_adl_abl = 1'b1;
                            o_zero_adh1_7 = 1'b1;
                            o_adh_abh = 1'b1;
                            o_adl_add = 1'b1;
                            o_sb_add = 1'b1;
                            o_sums = 1'b1;
                        end
                        cpu_pkg::T4:
                        begin
                            // read 01:ADD and write it back into S
                            o_add_adl = 1'b1;
                            o_adl_abl = 1'b1;
                            o_zero_adh1_7 = 1'b1;
                            o_adh_abh = 1'b1;
                            o_add_sb = 1'b1;
                            o_sb_s = 1'b1;
                        end
                        cpu_pkg::T5:
                        begin
                            // FFFC, low vector byte parked in ADD
                            o_zero_adl0 = 1'b1;
                            o_zero_adl1 = 1'b1;
                            o_adl_abl = 1'b1;
                            o_adh_abh = 1'b1;
                            o_dl_db = 1'b1;
                            o_db_add = 1'b1;
                            o_zero_add = 1'b1;
                            o_sums = 1'b1;
                        end
                        cpu_pkg::T6:
                        begin
                            // address FFFD comes from the precharged pattern,
                            // the buses carry the vector into PC
                            o_zero_adl1 = 1'b1;
                            o_dl_adh = 1'b1;
                            o_adh_pch = 1'b1;
                            o_add_adl = 1'b1;
                            o_adl_pcl = 1'b1;
                        end
                        cpu_pkg::T7:
                        begin
                            // first fetch at the vector
                            o_sync = 1'b1;
                            o_pcl_adl = 1'b1;
                            o_adl_abl = 1'b1;
                            o_pch_adh = 1'b1;
                            o_adh_abh = 1'b1;
                            o_pcl_pcl = 1'b1;
                            o_pch_pch = 1'b1;
                            o_i_pc = 1'b1;
                            o_tcu = cpu_pkg::T1;
                        end
                        default:
                        begin
                            o_tcu = cpu_pkg::T0;
                        end
                    endcase
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* program_counter.sv */
//##########################################################
// program counter
// PCL/PCH with recirculate, bus load and 16-bit increment
//##########################################################
`default_nettype none

module program_counter (
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  wire                 i_pcl_pcl,
    input  wire                 i_adl_pcl,
    input  wire                 i_pch_pch,
    input  wire                 i_adh_pch,
    input  wire                 i_i_pc,
    input  wire cpu_pkg::data_t i_adl,
    input  wire cpu_pkg::data_t i_adh,

    output cpu_pkg::data_t o_pcl,
    output cpu_pkg::data_t o_pch
);

    cpu_pkg::addr_t pc_src;
    cpu_pkg::addr_t pc_next;

    // each half picks its own register or the address bus
    assign pc_src = {i_adh_pch ? i_adh : o_pch, i_adl_pcl ? i_adl : o_pcl};

    // incrementer carries from PCL into PCH
    assign pc_next = pc_src + {15'd0, i_i_pc};

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_pcl <= 8'h00;
            o_pch <= 8'h00;
        end
        else
        begin
            if (i_pcl_pcl || i_adl_pcl)
            begin
                o_pcl <= pc_next[7:0];
            end
            if (i_pch_pch || i_adh_pch)
            begin
                o_pch <= pc_next[15:8];
            end
        end
    end

endmodule

`default_nettype wire

/* stack_adder.sv */
//##########################################################
// stack pointer and adder
// S register, adder inputs and the ADD hold register
//##########################################################
`default_nettype none

module stack_adder #(
    parameter cpu_pkg::data_t S_RESET = 8'h00
) (
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  wire                 i_s_adl,
    input  wire                 i_sb_s,
    input  wire                 i_adl_add,
    input  wire                 i_sb_add,
    input  wire                 i_db_add,
    input  wire                 i_zero_add,
    input  wire                 i_sums,
    input  wire                 i_add_sb,
    input  wire cpu_pkg::data_t i_adl,
    input  wire cpu_pkg::data_t i_db,

    output cpu_pkg::data_t o_s,
    output cpu_pkg::data_t o_add
);

    cpu_pkg::data_t s_reg;
    cpu_pkg::data_t a_op;
    cpu_pkg::data_t b_op;
    cpu_pkg::data_t sb;

    // A input, zero wins over the ADL load
    assign a_op = (i_adl_add && !i_zero_add) ? i_adl : 8'h00;

    // B input, precharged SB reads as all ones (the -1 operand)
    assign b_op = i_db_add ? i_db : (i_sb_add ? 8'hFF : 8'h00);

    // SB bus floats high unless ADD drives it
    assign sb = i_add_sb ? o_add : 8'hFF;

    always_ff @(posedge i_clk)
    begin
        if (i_sums)
        begin
            o_add <= a_op + b_op;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            s_reg <= S_RESET;
        end
        else if (i_sb_s)
        begin
            s_reg <= sb;
        end
    end

    // S pulls the ADL bus only when selected
    assign o_s = i_s_adl ? s_reg : 8'hFF;

endmodule

`default_nettype wire

/* tb_cpu.sv */
//##########################################################
// testbench for the 6502 front-end model
// random memory image, address sequence model and checks
//##########################################################
`default_nettype none

module tb_cpu;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int RUN_CYCLES = 2000;
    localparam int WATCHDOG_TIME = (RESET_CYCLES + RUN_CYCLES + 100) * CLK_PERIOD;
    localparam cpu_pkg::data_t S_INIT = 8'h02;

    logic           clk;
    logic           reset;
    cpu_pkg::data_t mem_rdata;
    cpu_pkg::addr_t o_addr;
    logic           o_rw;
    logic           o_sync;

    cpu_pkg::data_t mem [0:65535];
    integer         seed;
    int             errors;
    int             cycle;
    int             first_fetch;
    int             brk_passes;

    // reference model state
    int unsigned    t_m;
    cpu_pkg::data_t ir_m;
    cpu_pkg::data_t s_m;
    cpu_pkg::addr_t pc_m;
    cpu_pkg::addr_t exp_addr;
    logic           exp_sync;

    cpu_top #(
        .S_RESET (S_INIT)
    ) u_cpu_top (
        .i_clk   (clk),
        .i_reset (reset),
        .i_data  (mem_rdata),
        .o_addr  (o_addr),
        .o_rw    (o_rw),
        .o_sync  (o_sync)
    );

    // asynchronous read with data in the same cycle
    assign mem_rdata = (^o_addr === 1'bx) ? 8'h00 : mem[o_addr];

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_value(input logic [15:0] actual, input logic [15:0] expected,
                                 input string what);
        if (actual !== expected)
        begin
            errors = errors + 1;
            $display("Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // opcodes are mostly NOP with some other bytes and a few BRK
    task automatic fill_memory();
        logic [16:0] idx;
        logic [31:0] rnd;
        int unsigned pick;
        for (idx = 17'd0; idx < 17'h10000; idx = idx + 17'd1)
        begin
            rnd = $random(seed);
            pick = rnd % 100;
            rnd = $random(seed);
            if (pick < 80)
            begin
                mem[idx[15:0]] = cpu_pkg::OPCODE_NOP;
            end
            else if (pick < 95)
            begin
                mem[idx[15:0]] = rnd[7:0];
            end
            else
            begin
                mem[idx[15:0]] = cpu_pkg::OPCODE_BRK;
            end
        end
        rnd = $random(seed);
        mem[{8'hFF, cpu_pkg::VEC_RESET_LO}] = rnd[7:0];
        mem[{8'hFF, cpu_pkg::VEC_RESET_HI}] = rnd[15:8];
    endtask

    // expected bus for the current T state before stepping on
    task automatic model_cycle(output cpu_pkg::addr_t addr, output logic sync);
        sync = 1'b0;
        addr = pc_m;
        case (t_m)
            0, 7:
            begin
                sync = 1'b1;
                ir_m = mem[pc_m];
                pc_m = pc_m + 16'd1;
                t_m = 1;
            end
            1:
            begin
                t_m = (ir_m == cpu_pkg::OPCODE_BRK) ? 2 : 0;
            end
            2:
            begin
                addr = {cpu_pkg::STACK_PAGE, s_m};
                t_m = 3;
            end
            3:
            begin
                addr = {cpu_pkg::STACK_PAGE, s_m - 8'd1};
                t_m = 4;
            end
            4:
            begin
                addr = {cpu_pkg::STACK_PAGE, s_m - 8'd2};
                s_m = s_m - 8'd2;
                brk_passes = brk_passes + 1;
                t_m = 5;
            end
            5:
            begin
                addr = {8'hFF, cpu_pkg::VEC_RESET_LO};
                t_m = 6;
            end
            default:
            begin
                addr = {8'hFF, cpu_pkg::VEC_RESET_HI};
                pc_m = {mem[{8'hFF, cpu_pkg::VEC_RESET_HI}], mem[{8'hFF, cpu_pkg::VEC_RESET_LO}]};
                t_m = 7;
            end
        endcase
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        seed = 32'h69c0c1b3;
        errors = 0;
        first_fetch = -1;
        brk_passes = 0;
        fill_memory();

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // reset leaves the core at T2 of a forced BRK
        t_m = 2;
        ir_m = cpu_pkg::OPCODE_BRK;
        s_m = S_INIT;
        pc_m = 16'h0000;

        for (cycle = 0; cycle < RUN_CYCLES; cycle = cycle + 1)
        begin
            model_cycle(exp_addr, exp_sync);
            compare_value(o_addr, exp_addr, "o_addr");
            compare_value(16'(o_sync), 16'(exp_sync), "o_sync");
            compare_value(16'(o_rw), 16'h0001, "o_rw");
            if (o_sync === 1'b1 && first_fetch < 0)
            begin
                first_fetch = cycle;
            end
            @(negedge clk);
        end

        // T2 to T7 puts the vector fetch in the sixth cycle
        compare_value(16'(first_fetch), 16'd5, "first fetch cycle");
        if (brk_passes < 2)
        begin
            $display("No fetched BRK was seen, the repeat of the sequence went untested");
            errors = errors + 1;
        end

        if (errors == 0)
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
        else
        begin
            $display("CHECKS FAILED");
            $fatal(1, "run ended with errors");
        end
    end

    initial
    begin
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* timing_ctrl.sv */
//##########################################################
// timing control
// TCU and IR registers, reset enters the BRK sequence
//##########################################################
`default_nettype none

module timing_ctrl (
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  wire cpu_pkg::tcu_t  i_tcu_next,
    input  wire                 i_sync,
    input  wire cpu_pkg::data_t i_data,

    output cpu_pkg::tcu_t  o_tcu,
    output cpu_pkg::data_t o_ir
);

    // T state follows the decode ROM every cycle
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_tcu <= cpu_pkg::TCU_RESET;
        end
        else
        begin
            o_tcu <= i_tcu_next;
        end
    end

    // opcode latched at the end of a fetch cycle
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            // reset runs as a forced BRK
            o_ir <= cpu_pkg::OPCODE_BRK;
        end
        else if (i_sync)
        begin
            o_ir <= i_data;
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
cpu_pkg.sv
decoder.sv
timing_ctrl.sv
program_counter.sv
stack_adder.sv
bus_unit.sv
cpu_top.sv
cpu_sva.sv
tb_cpu.sv
